//--- dcache_top.f
dcache_pkg.sv
dcache_ctrl.sv
dcache_tag_array.sv
dcache_data_array.sv
dcache_plru.sv
dcache_top.sv
dcache_chk.sv
tb_dcache_scoreboard.sv
tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_ctrl.sv
  - dcache_tag_array.sv
  - dcache_data_array.sv
  - dcache_plru.sv
  - dcache_top.sv
  - target: test
    files:
      - dcache_chk.sv
      - tb_dcache_scoreboard.sv
      - tb_dcache.sv

//--- tb_dcache.sv
module tb_dcache;
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    localparam int NUM_SETS = 16;
    localparam int TAG_W    = 20;
    localparam int DATA_W   = 64;
    localparam int IDX_W    = $clog2(NUM_SETS);
    localparam int ADDR_W   = TAG_W + IDX_W + OFFSET_W;
    localparam int TIMEOUT  = 200;

    logic                clk;
    logic                rst_n;
    logic                rden;
    logic                wren;
    logic                rep;
    logic [IDX_W-1:0]    idx;
    logic [TAG_W-1:0]    tag;
    logic [DATA_W/8-1:0] wmask;
    logic [DATA_W-1:0]   wdat;
    logic [DATA_W-1:0]   rep_dat;
    logic                hit;
    logic [DATA_W-1:0]   rdat;
    logic                wb;
    logic [ADDR_W-1:0]   wb_addr;
    logic [DATA_W-1:0]   wb_dat;
    logic [31:0]         lfsr;
    logic [TAG_W-1:0]    tag_tab [5];
    logic                missed;
    logic                timed_out;
    int                  req_cnt;

    always #4 clk = ~clk;

    dcache_top #(
        .NUM_SETS (NUM_SETS),
        .TAG_W    (TAG_W),
        .DATA_W   (DATA_W)
    ) i_dut (
        .clk (clk), .i_rst_n (rst_n), .i_rden (rden), .i_wren (wren), .i_rep (rep),
        .i_idx (idx), .i_tag (tag), .i_wmask (wmask), .i_wdat (wdat), .i_rep_dat (rep_dat),
        .o_hit (hit), .o_rdat (rdat), .o_wb (wb), .o_wb_addr (wb_addr), .o_wb_dat (wb_dat)
    );

    tb_dcache_scoreboard #(
        .NUM_SETS (NUM_SETS),
        .TAG_W    (TAG_W),
        .DATA_W   (DATA_W)
    ) u_sb (
        .clk (clk), .i_rst_n (rst_n), .i_rden (rden), .i_wren (wren), .i_rep (rep),
        .i_idx (idx), .i_tag (tag), .i_wmask (wmask), .i_wdat (wdat), .i_rep_dat (rep_dat),
        .i_hit (hit), .i_rdat (rdat), .i_wb (wb), .i_wb_addr (wb_addr), .i_wb_dat (wb_dat)
    );

    bind dcache_top dcache_chk #(
        .ADDR_W (ADDR_W)
    ) u_chk (
        .clk (clk), .i_rst_n (i_rst_n), .i_rden (i_rden), .i_wren (i_wren), .i_rep (i_rep),
        .i_hit (o_hit), .i_wb (o_wb), .i_wb_addr (o_wb_addr)
    );

    // Galois LFSR stepped once per bit
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[62:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'ha300_0000 : 32'h0);
        end
        return r;
    endfunction

    // kind 0 read, 1 write, 2 refill
    task automatic drive_req(input int kind, input int s, input int t, output logic miss);
        rden    = (kind == 0);
        wren    = (kind == 1);
        rep     = (kind == 2);
        idx     = s;
        tag     = tag_tab[t];
        wmask   = rand_bits(DATA_W / 8);
        wdat    = rand_bits(DATA_W);
        rep_dat = rand_bits(DATA_W);
        req_cnt++;
        @(negedge clk);
        miss = !hit;
        @(posedge clk);
        #1;
        rden = 1'b0;
        wren = 1'b0;
        rep  = 1'b0;
    endtask

    task automatic access(input int kind, input int s, input int t);
        logic miss;
        drive_req(kind, s, t, miss);
        if (miss) begin
            drive_req(2, s, t, miss);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!u_sb.ready && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!u_sb.ready) begin
            timed_out = 1'b1;
            $display("Timed out waiting for the end of reset");
        end
    endtask

    task automatic finish_test();
        int n;
        n = 0;
        while (u_sb.req_cnt != req_cnt && n < TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (u_sb.req_cnt != req_cnt) begin
            timed_out = 1'b1;
            $display("Timed out waiting for the scoreboard in test %s", u_sb.test_name);
        end
        u_sb.end_test();
    endtask

    task automatic run_tests();
        int s;
        int t;
        u_sb.start_test("reset_miss");
        repeat (8) begin
            drive_req(0, rand_bits(IDX_W), rand_bits(3) % 5, missed);
        end
        finish_test();

        u_sb.start_test("refill_hit");
        for (int i = 0; i < 4; i++) begin
            s = rand_bits(3);
            access(0, s, i);
            drive_req(0, s, i, missed);
        end
        finish_test();

        u_sb.start_test("write_merge");
        repeat (6) begin
            s = rand_bits(3);
            t = rand_bits(1);
            access(0, s, t);
            access(1, s, t);
            drive_req(0, s, t, missed);
        end
        finish_test();

        // Sets 12 and 13 are untouched by the tests above
        u_sb.start_test("victim_order");
        for (int i = 0; i < 5; i++) begin
            access(0, 12, i);
        end
        for (int i = 0; i < 5; i++) begin
            drive_req(0, 12, i, missed);
        end
        finish_test();

        u_sb.start_test("dirty_writeback");
        for (int i = 0; i < 4; i++) begin
            access(1, 13, i);
            access(1, 13, i);
        end
        access(0, 13, 4);
        repeat (6) begin
            access(rand_bits(1), 13, rand_bits(3) % 5);
        end
        finish_test();

        u_sb.start_test("random");
        repeat (400) begin
            if (rand_bits(3) == 0) begin
                @(posedge clk);
                #1;
            end
            access(rand_bits(1), rand_bits(IDX_W), rand_bits(2) % 3);
        end
        finish_test();
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        rden      = 1'b0;
        wren      = 1'b0;
        rep       = 1'b0;
        idx       = '0;
        tag       = '0;
        wmask     = '0;
        wdat      = '0;
        rep_dat   = '0;
        req_cnt   = 0;
        timed_out = 1'b0;
        lfsr      = 32'hb515_d579;
        tag_tab   = '{20'h0_1a3c, 20'h5_5d01, 20'ha_2f70, 20'h3_c4e9, 20'hf_0b12};
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_ready();
        if (!timed_out) begin
            run_tests();
        end
        $display("Tests: %0d passed, %0d failed, %0d value errors, %0d assertion failures",
                 u_sb.pass_cnt, u_sb.fail_cnt, u_sb.err_cnt, i_dut.u_chk.fail_cnt);
        if (timed_out || u_sb.fail_cnt != 0 || u_sb.err_cnt != 0 ||
            i_dut.u_chk.fail_cnt != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

//--- tb_dcache_scoreboard.sv
module tb_dcache_scoreboard #(
    parameter int NUM_SETS = 16,
    parameter int TAG_W = 20,
    parameter int DATA_W = 64,
    localparam int IDX_W = $clog2(NUM_SETS),
    localparam int ADDR_W = TAG_W + IDX_W + dcache_pkg::OFFSET_W
) (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_rden,
    input  logic                i_wren,
    input  logic                i_rep,
    input  logic [IDX_W-1:0]    i_idx,
    input  logic [TAG_W-1:0]    i_tag,
    input  logic [DATA_W/8-1:0] i_wmask,
    input  logic [DATA_W-1:0]   i_wdat,
    input  logic [DATA_W-1:0]   i_rep_dat,
    input  logic                i_hit,
    input  logic [DATA_W-1:0]   i_rdat,
    input  logic                i_wb,
    input  logic [ADDR_W-1:0]   i_wb_addr,
    input  logic [DATA_W-1:0]   i_wb_dat
);
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    logic              vld_m   [NUM_SETS][NUM_WAYS];
    logic              dirty_m [NUM_SETS][NUM_WAYS];
    logic [TAG_W-1:0]  tag_m   [NUM_SETS][NUM_WAYS];
    logic [DATA_W-1:0] dat_m   [NUM_SETS][NUM_WAYS];
    logic [2:0]        tree_m  [NUM_SETS];
    logic              miss_m;
    logic              ready = 1'b0;
    string             test_name = "idle";
    int                req_cnt = 0;
    int                err_cnt = 0;
    int                pass_cnt = 0;
    int                fail_cnt = 0;
    int                test_checks;
    int                test_errs;
    int                wb_seen;

    function automatic int victim_of(int s);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!vld_m[s][w]) begin
                return w;
            end
        end
        // Full set, follow the tree from the root
        if (tree_m[s][0]) begin
            return tree_m[s][2] ? 3 : 2;
        end
        return tree_m[s][1] ? 1 : 0;
    endfunction

    function automatic void touch(int s, int w);
        tree_m[s][0] = (w < 2);
        if (w < 2) begin
            tree_m[s][1] = (w == 0);
        end else begin
            tree_m[s][2] = (w == 2);
        end
    endfunction

    task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
        test_checks++;
        if (exp !== act) begin
            test_errs++;
            err_cnt++;
            $display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic lookup();
        int   s;
        int   hw;
        int   vw;
        logic hit;
        logic exp_wb;
        s   = i_idx;
        hit = 1'b0;
        hw  = 0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (vld_m[s][w] && tag_m[s][w] == i_tag) begin
                hit = 1'b1;
                hw  = w;
            end
        end
        vw     = victim_of(s);
        exp_wb = !hit && vld_m[s][vw] && dirty_m[s][vw];
        check("hit", hit, i_hit);
        check("wb", exp_wb, i_wb);
        if (hit && i_rden) begin
            check("rdat", dat_m[s][hw], i_rdat);
        end
        if (exp_wb) begin
            wb_seen++;
            check("wb_addr", {tag_m[s][vw], i_idx, {OFFSET_W{1'b0}}}, i_wb_addr);
            check("wb_dat", dat_m[s][vw], i_wb_dat);
        end
        if (hit && i_wren) begin
            for (int b = 0; b < DATA_W / BYTE_W; b++) begin
                if (i_wmask[b]) begin
                    dat_m[s][hw][b*BYTE_W +: BYTE_W] = i_wdat[b*BYTE_W +: BYTE_W];
                end
            end
            dirty_m[s][hw] = 1'b1;
        end
        if (hit) begin
            touch(s, hw);
        end
        miss_m = !hit;
    endtask

    task automatic refill();
        int vw;
        check("wb", 1'b0, i_wb);
        // Only a refill right after a miss allocates
        if (miss_m) begin
            vw = victim_of(i_idx);
            tag_m[i_idx][vw]   = i_tag;
            dat_m[i_idx][vw]   = i_rep_dat;
            vld_m[i_idx][vw]   = 1'b1;
            dirty_m[i_idx][vw] = 1'b0;
            touch(i_idx, vw);
        end
        miss_m = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errs   = 0;
        wb_seen     = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            pass_cnt++;
            $display("PASS %s: %0d checks, %0d writebacks", test_name, test_checks, wb_seen);
        end else begin
            fail_cnt++;
            $display("FAIL %s: %0d of %0d checks wrong", test_name, test_errs, test_checks);
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        ready = i_rst_n;
        if (!i_rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    vld_m[s][w]   = 1'b0;
                    dirty_m[s][w] = 1'b0;
                end
                tree_m[s] = '0;
            end
            miss_m = 1'b0;
        end else if (i_rden || i_wren) begin
            req_cnt++;
            lookup();
        end else if (i_rep) begin
            req_cnt++;
            refill();
        end else begin
            miss_m = 1'b0;
        end
    end

endmodule

//--- dcache_chk.sv
module dcache_chk #(
    parameter int ADDR_W = 30
) (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_rden,
    input  logic                i_wren,
    input  logic                i_rep,
    input  logic                i_hit,
    input  logic                i_wb,
    input  logic [ADDR_W-1:0]   i_wb_addr
);
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    int fail_cnt = 0;

    one_request: assert property (@(posedge clk) disable iff (!i_rst_n)
        $onehot0({i_rden, i_wren, i_rep}))
    else begin
        fail_cnt++;
        $error("more than one request in a cycle");
    end

    no_wb_on_hit: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_wb && i_hit))
    else begin
        fail_cnt++;
        $error("writeback strobe raised on a hit");
    end

    wb_needs_lookup: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wb |-> (i_rden || i_wren))
    else begin
        fail_cnt++;
        $error("writeback strobe without a read or write");
    end

    // Line aligned writeback address
    wb_addr_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wb_addr[OFFSET_W-1:0] == '0)
    else begin
        fail_cnt++;
        $error("writeback address has a nonzero offset");
    end

endmodule

//--- dcache_top.sv
module dcache_top #(
    parameter int NUM_SETS = dcache_pkg::DEF_NUM_SETS,
    parameter int TAG_W = dcache_pkg::DEF_TAG_W,
    parameter int DATA_W = dcache_pkg::DEF_DATA_W,
    localparam int IDX_W = $clog2(NUM_SETS),
    localparam int MASK_W = DATA_W / dcache_pkg::BYTE_W,
    localparam int ADDR_W = TAG_W + IDX_W + dcache_pkg::OFFSET_W
) (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_rden,
    input  logic                i_wren,
    input  logic                i_rep,
    input  logic [IDX_W-1:0]    i_idx,
    input  logic [TAG_W-1:0]    i_tag,
    input  logic [MASK_W-1:0]   i_wmask,
    input  logic [DATA_W-1:0]   i_wdat,
    input  logic [DATA_W-1:0]   i_rep_dat,
    output logic                o_hit,
    output logic [DATA_W-1:0]   o_rdat,
    output logic                o_wb,
    output logic [ADDR_W-1:0]   o_wb_addr,
    output logic [DATA_W-1:0]   o_wb_dat
);
    import dcache_pkg::*;

    way_vec_t                         vld;
    way_vec_t                         dirty;
    logic [NUM_WAYS-1:0][TAG_W-1:0]   tags;
    way_t                             plru_way;
    way_t                             hit_way;
    way_t                             victim_way;
    way_vec_t                         fill_en;
    way_vec_t                         dirty_set;
    logic [NUM_WAYS-1:0][MASK_W-1:0]  byte_en;
    logic                             touch;
    way_t                             touch_way;
    logic [TAG_W-1:0]                 victim_tag;

    dcache_ctrl #(
        .TAG_W  (TAG_W),
        .DATA_W (DATA_W)
    ) u_ctrl (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_rden       (i_rden),
        .i_wren       (i_wren),
        .i_rep        (i_rep),
        .i_wmask      (i_wmask),
        .i_vld        (vld),
        .i_dirty      (dirty),
        .i_tags       (tags),
        .i_tag        (i_tag),
        .i_plru_way   (plru_way),
        .o_hit        (o_hit),
        .o_hit_way    (hit_way),
        .o_victim_way (victim_way),
        .o_fill_en    (fill_en),
        .o_dirty_set  (dirty_set),
        .o_byte_en    (byte_en),
        .o_touch      (touch),
        .o_touch_way  (touch_way),
        .o_wb         (o_wb)
    );

    dcache_tag_array #(
        .NUM_SETS (NUM_SETS),
        .TAG_W    (TAG_W)
    ) u_tag_array (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_idx       (i_idx),
        .i_tag       (i_tag),
        .i_fill_en   (fill_en),
        .i_dirty_set (dirty_set),
        .o_vld       (vld),
        .o_dirty     (dirty),
        .o_tags      (tags)
    );

    dcache_data_array #(
        .NUM_SETS (NUM_SETS),
        .DATA_W   (DATA_W)
    ) u_data_array (
        .clk          (clk),
        .i_idx        (i_idx),
        .i_byte_en    (byte_en),
        .i_rep        (i_rep),
        .i_wdat       (i_wdat),
        .i_rep_dat    (i_rep_dat),
        .i_hit_way    (hit_way),
        .i_victim_way (victim_way),
        .o_rdat       (o_rdat),
        .o_victim_dat (o_wb_dat)
    );

    dcache_plru #(
        .NUM_SETS (NUM_SETS)
    ) u_plru (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_idx       (i_idx),
        .i_touch     (touch),
        .i_touch_way (touch_way),
        .o_plru_way  (plru_way)
    );

    // Line address of the evicted line
    assign victim_tag = tags[victim_way];
    assign o_wb_addr  = {victim_tag, i_idx, {OFFSET_W{1'b0}}};

endmodule

//--- dcache_plru.sv
module dcache_plru #(
    parameter int NUM_SETS = dcache_pkg::DEF_NUM_SETS,
    localparam int IDX_W = $clog2(NUM_SETS)
) (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic [IDX_W-1:0]    i_idx,
    input  logic                i_touch,
    input  dcache_pkg::way_t    i_touch_way,
    output dcache_pkg::way_t    o_plru_way
);
    import dcache_pkg::*;

    plru_t plru_q [NUM_SETS];
    plru_t cur;
    plru_t nxt;

    assign cur = plru_q[i_idx];

    // Walk down from the root
    assign o_plru_way = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

    // Point the nodes on the path away from the touched way
    always_comb begin
        nxt    = cur;
        nxt[0] = ~i_touch_way[1];
        if (i_touch_way[1]) begin
            nxt[2] = ~i_touch_way[0];
        end else begin
            nxt[1] = ~i_touch_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                plru_q[s] <= '0;
            end
        end else if (i_touch) begin
            plru_q[i_idx] <= nxt;
        end
    end

endmodule

//--- dcache_data_array.sv
module dcache_data_array #(
    parameter int NUM_SETS = dcache_pkg::DEF_NUM_SETS,
    parameter int DATA_W = dcache_pkg::DEF_DATA_W,
    localparam int IDX_W = $clog2(NUM_SETS),
    localparam int MASK_W = DATA_W / dcache_pkg::BYTE_W
) (
    input  logic                                          clk,
    input  logic [IDX_W-1:0]                              i_idx,
    input  logic [dcache_pkg::NUM_WAYS-1:0][MASK_W-1:0]   i_byte_en,
    input  logic                                          i_rep,
    input  logic [DATA_W-1:0]                             i_wdat,
    input  logic [DATA_W-1:0]                             i_rep_dat,
    input  dcache_pkg::way_t                              i_hit_way,
    input  dcache_pkg::way_t                              i_victim_way,
    output logic [DATA_W-1:0]                             o_rdat,
    output logic [DATA_W-1:0]                             o_victim_dat
);
    import dcache_pkg::*;

    logic [DATA_W-1:0] mem_q [NUM_WAYS][NUM_SETS];
    logic [DATA_W-1:0] wr_dat;

    // Refill data wins over store data
    assign wr_dat = i_rep ? i_rep_dat : i_wdat;

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int b = 0; b < MASK_W; b++) begin
                if (i_byte_en[w][b]) begin
                    mem_q[w][i_idx][b*BYTE_W +: BYTE_W] <= wr_dat[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    assign o_rdat       = mem_q[i_hit_way][i_idx];
    assign o_victim_dat = mem_q[i_victim_way][i_idx];

endmodule

//--- dcache_tag_array.sv
module dcache_tag_array #(
    parameter int NUM_SETS = dcache_pkg::DEF_NUM_SETS,
    parameter int TAG_W = dcache_pkg::DEF_TAG_W,
    localparam int IDX_W = $clog2(NUM_SETS)
) (
    input  logic                                          clk,
    input  logic                                          i_rst_n,
    input  logic [IDX_W-1:0]                              i_idx,
    input  logic [TAG_W-1:0]                              i_tag,
    input  dcache_pkg::way_vec_t                          i_fill_en,
    input  dcache_pkg::way_vec_t                          i_dirty_set,
    output dcache_pkg::way_vec_t                          o_vld,
    output dcache_pkg::way_vec_t                          o_dirty,
    output logic [dcache_pkg::NUM_WAYS-1:0][TAG_W-1:0]    o_tags
);
    import dcache_pkg::*;

    way_vec_t                         vld_q   [NUM_SETS];
    way_vec_t                         dirty_q [NUM_SETS];
    logic [NUM_WAYS-1:0][TAG_W-1:0]   tag_q   [NUM_SETS];
    logic                             upd;

    assign upd = (|i_fill_en) || (|i_dirty_set);

    // Line state of every set
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                vld_q[s]   <= '0;
                dirty_q[s] <= '0;
            end
        end else if (upd) begin
            vld_q[i_idx]   <= vld_q[i_idx] | i_fill_en;
            // A fresh line starts clean
            dirty_q[i_idx] <= (dirty_q[i_idx] | i_dirty_set) & ~i_fill_en;
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (i_fill_en[w]) begin
                tag_q[i_idx][w] <= i_tag;
            end
        end
    end

    assign o_vld   = vld_q[i_idx];
    assign o_dirty = dirty_q[i_idx];
    assign o_tags  = tag_q[i_idx];

endmodule

//--- dcache_ctrl.sv
module dcache_ctrl #(
    parameter int TAG_W = dcache_pkg::DEF_TAG_W,
    parameter int DATA_W = dcache_pkg::DEF_DATA_W,
    localparam int MASK_W = DATA_W / dcache_pkg::BYTE_W
) (
    input  logic                                          clk,
    input  logic                                          i_rst_n,
    input  logic                                          i_rden,
    input  logic                                          i_wren,
    input  logic                                          i_rep,
    input  logic [MASK_W-1:0]                             i_wmask,
    input  dcache_pkg::way_vec_t                          i_vld,
    input  dcache_pkg::way_vec_t                          i_dirty,
    input  logic [dcache_pkg::NUM_WAYS-1:0][TAG_W-1:0]    i_tags,
    input  logic [TAG_W-1:0]                              i_tag,
    input  dcache_pkg::way_t                              i_plru_way,
    output logic                                          o_hit,
    output dcache_pkg::way_t                              o_hit_way,
    output dcache_pkg::way_t                              o_victim_way,
    output dcache_pkg::way_vec_t                          o_fill_en,
    output dcache_pkg::way_vec_t                          o_dirty_set,
    output logic [dcache_pkg::NUM_WAYS-1:0][MASK_W-1:0]   o_byte_en,
    output logic                                          o_touch,
    output dcache_pkg::way_t                              o_touch_way,
    output logic                                          o_wb
);
    import dcache_pkg::*;

    way_vec_t hit_vec;
    way_t     free_way;
    logic     free_found;
    logic     lookup;
    logic     fill;
    logic     miss_q;

    assign lookup = i_rden | i_wren;

    // Tag compare on all ways of the set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = i_vld[w] && (i_tags[w] == i_tag);
        end
    end

    assign o_hit = |hit_vec;

    always_comb begin
        o_hit_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                o_hit_way = way_t'(w);
            end
        end
    end

    // Lowest invalid way first
    always_comb begin
        free_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!i_vld[w]) begin
                free_way = way_t'(w);
            end
        end
    end

    assign free_found   = ~&i_vld;
    assign o_victim_way = free_found ? free_way : i_plru_way;

    // Remembers a read or write miss, the refill must come right after it
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            miss_q <= 1'b0;
        end else begin
            miss_q <= lookup && !o_hit;
        end
    end

    assign fill = i_rep && miss_q;

    assign o_fill_en   = fill ? (way_vec_t'(1) << o_victim_way) : way_vec_t'(0);
    assign o_dirty_set = {NUM_WAYS{i_wren}} & hit_vec;

    // Refill writes the whole line, a write hit only its masked bytes
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            o_byte_en[w] = '0;
            if (o_fill_en[w]) begin
                o_byte_en[w] = '1;
            end else if (o_dirty_set[w]) begin
                o_byte_en[w] = i_wmask;
            end
        end
    end

    assign o_touch     = (lookup && o_hit) || fill;
    assign o_touch_way = fill ? o_victim_way : o_hit_way;

    // Miss that would evict a modified line
    assign o_wb = lookup && !o_hit && i_vld[o_victim_way] && i_dirty[o_victim_way];

endmodule

//--- dcache_pkg.sv
package dcache_pkg;

    // Cache geometry
    localparam int NUM_WAYS = 4;
    localparam int BYTE_W   = 8;

    // Line offset bits of the writeback address, always zero
    localparam int OFFSET_W = 6;

    // Defaults for the top level parameters
    localparam int DEF_TAG_W    = 20;
    localparam int DEF_DATA_W   = 64;
    localparam int DEF_NUM_SETS = 256;

    // Way number
    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    // One bit per way: valid, dirty, hit and write enables
    typedef logic [NUM_WAYS-1:0] way_vec_t;

    // Tree PLRU state
    // bit 0 root, 0 points at ways 0/1, 1 points at ways 2/3
    // bit 1 node over ways 0/1, bit 2 node over ways 2/3
    typedef logic [2:0] plru_t;

endpackage
